//--- all.f
design/fxp_pkg.sv
design/cmd_decoder.sv
design/fxp_mac.sv
design/signed_cast.sv
design/fxp_scaler_top.sv
test/fxp_scaler_sva.sv
test/fxp_scaler_tb.sv

//--- Bender.yml
package:
  name: fxp_scaler

sources:
  - files:
      - design/fxp_pkg.sv
      - design/cmd_decoder.sv
      - design/fxp_mac.sv
      - design/signed_cast.sv
      - design/fxp_scaler_top.sv
  - target: test
    files:
      - test/fxp_scaler_sva.sv
      - test/fxp_scaler_tb.sv

//--- test/fxp_scaler_tb.sv
/* fixed point scaler testbench
   random commands, reference model and in-order checks of every result */

`timescale 1ns/1ps
`default_nettype none

module fxp_scaler_tb
    import fxp_pkg::*;
();

    localparam int HALF_PERIOD  = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 10;
    // about 660 words plus random idle gaps come to roughly 1000 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                    clk;
    logic                    reset;
    logic [CMD_W-1:0]        in_word;
    logic                    in_valid;
    logic signed [OUT_W-1:0] out_word;
    logic                    out_valid;
    logic                    out_sat;

    // reference model state
    logic signed [COEF_W-1:0] model_gain = COEF_ONE;
    logic signed [ACC_W-1:0]  model_acc  = '0;

    // expected {sat, word} results with the oldest first
    logic [OUT_W:0] expected_q[$];
    logic [OUT_W:0] expected;

    integer seed;
    int     cycle_count = 0;

    fxp_scaler_top u_fxp_scaler_top (
        .clk       (clk),
        .reset     (reset),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_sat   (out_sat)
    );

    bind fxp_scaler_top fxp_scaler_sva u_fxp_scaler_sva (
        .clk       (clk),
        .reset     (reset),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out_sat   (out_sat)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // expected {sat, word} of one sample command
    // also moves the model accumulator on
    function automatic logic [OUT_W:0] model_sample(input cmd_word_u w);
        logic signed [SAMPLE_W-1:0] data;
        longint prod;
        longint res;
        longint trunc;
        longint max_val;
        longint min_val;
        logic [OUT_W-1:0] word;
        logic sat;
        data    = signed'(w.sample_view.data);
        prod    = longint'(data) * longint'(model_gain);
        max_val = (longint'(1) <<< (OUT_W - 1)) - 1;
        min_val = -(longint'(1) <<< (OUT_W - 1));
        case (w.sample_view.op)
            OP_MUL: begin
                model_acc = prod[ACC_W-1:0];
                res = longint'(model_acc);
            end
            OP_MAC: begin
                // sum wraps at 34 bits
                model_acc = model_acc + prod[ACC_W-1:0];
                res = longint'(model_acc);
            end
            default: begin
                res = longint'(data) * (longint'(1) <<< (ACC_POINT - SAMPLE_POINT));
            end
        endcase
        // arithmetic shift floors toward minus infinity
        trunc = res >>> (ACC_POINT - OUT_POINT);
        sat   = 1'b1;
        if (trunc > max_val) begin
            word = max_val[OUT_W-1:0];
        end else if (trunc < min_val) begin
            word = min_val[OUT_W-1:0];
        end else begin
            word = trunc[OUT_W-1:0];
            sat  = 1'b0;
        end
        return {sat, word};
    endfunction

    // samples in -8.0 .. +8.0
    function automatic logic [SAMPLE_W-1:0] small_data();
        logic [SAMPLE_W-1:0] r;
        r = $random(seed);
        return {{4{r[11]}}, r[11:0]};
    endfunction

    // samples with magnitude 64.0 .. 128.0
    function automatic logic [SAMPLE_W-1:0] large_data();
        logic [SAMPLE_W-1:0] r;
        logic [SAMPLE_W-1:0] mag;
        r   = $random(seed);
        mag = {2'b01, r[13:0]};
        return r[15] ? -mag : mag;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic signed [OUT_W-1:0] exp_word,
                              input logic signed [OUT_W-1:0] act_word);
        if (act_word !== exp_word) begin
            abort_run($sformatf("FAIL time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp_word, act_word));
        end
    endtask

    task automatic check_sat(input string name, input logic exp_bit, input logic act_bit);
        if (act_bit !== exp_bit) begin
            abort_run($sformatf("FAIL time=%0t %s expected=%b actual=%b",
                                $time, name, exp_bit, act_bit));
        end
    endtask

    // one word per cycle with the model kept in DUT order
    task automatic drive_word(input cmd_word_u w);
        @(posedge clk);
        #DRIVE_DELAY;
        in_word  = w;
        in_valid = 1'b1;
        if (w.sample_view.kind == KIND_SAMPLE) begin
            expected_q.push_back(model_sample(w));
        end else begin
            model_gain = signed'(w.coef_view.coef);
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
        end
    endtask

    task automatic send_sample(input logic [1:0] op, input logic [SAMPLE_W-1:0] data);
        cmd_word_u w;
        w.sample_view.kind = KIND_SAMPLE;
        w.sample_view.op   = op;
        // reserved bits must be ignored
        w.sample_view.rsvd = $random(seed);
        w.sample_view.data = data;
        drive_word(w);
    endtask

    task automatic send_coef(input logic [COEF_W-1:0] coef);
        cmd_word_u w;
        w.coef_view.kind = KIND_COEF;
        w.coef_view.rsvd = $random(seed);
        w.coef_view.coef = coef;
        drive_word(w);
    endtask

    // compare at the falling edge away from the register updates
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (expected_q.size() == 0) begin
                abort_run("an output arrived with no sample command waiting for it");
            end else begin
                expected = expected_q.pop_front();
                check_word("out_word", expected[OUT_W-1:0], out_word);
                check_sat("out_sat", expected[OUT_W], out_sat);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        seed     = 32'h79f4;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // pass and the reserved code return the sample itself
        for (int i = 0; i < 20; i++) begin
            send_sample(($random(seed) & 1) ? OP_PASS : 2'b11, $random(seed));
        end

        // default gain of one
        for (int i = 0; i < 20; i++) begin
            send_sample(OP_MUL, $random(seed));
        end

        // random gains with one idle cycle after each load
        for (int i = 0; i < 30; i++) begin
            send_coef($random(seed));
            drive_idle(1);
            send_sample(OP_MUL, $random(seed));
            send_sample(OP_MUL, $random(seed));
        end

        // load directly followed by the sample that must see it
        for (int i = 0; i < 40; i++) begin
            send_coef($random(seed));
            send_sample(OP_MUL, $random(seed));
        end

        // MAC chains with pass commands mixed in
        for (int i = 0; i < 15; i++) begin
            send_coef({{2{1'b0}}, 14'($random(seed))});
            send_sample(OP_MUL, small_data());
            for (int j = 0; j < 6; j++) begin
                send_sample(($random(seed) & 1) ? OP_MAC : OP_PASS, small_data());
            end
        end

        // gains near +2 and -2 with a large then a small sample
        for (int i = 0; i < 40; i++) begin
            send_coef((i % 2) ? (16'h8000 | (16'($random(seed)) & 16'h00ff))
                              : (16'h7f00 | (16'($random(seed)) & 16'h00ff)));
            send_sample(OP_MUL, large_data());
            send_sample(OP_MUL, small_data());
        end

        // long chains that run past both limits
        send_coef(COEF_ONE);
        send_sample(OP_MUL, 16'sh4000);
        for (int j = 0; j < 5; j++) begin
            send_sample(OP_MAC, 16'sh5000);
        end
        send_sample(OP_MUL, -16'sh4000);
        for (int j = 0; j < 5; j++) begin
            send_sample(OP_MAC, -16'sh5000);
        end

        // mixed traffic with idle gaps
        for (int i = 0; i < 200; i++) begin
            if (($random(seed) & 3) == 0) begin
                send_coef($random(seed));
            end else begin
                send_sample(2'($random(seed)), $random(seed));
            end
            drive_idle({$random(seed)} % 3);
        end

        drive_idle(1);
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // a few idle cycles to catch any late extra result
        drive_idle(5);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/fxp_scaler_sva.sv
/* scaler top level assertions
   output strobe latency, reset state and the saturation flag */

`timescale 1ns/1ps
`default_nettype none

module fxp_scaler_sva
    import fxp_pkg::*;
(
    input wire logic             clk,
    input wire logic             reset,
    input wire logic [CMD_W-1:0] in_word,
    input wire logic             in_valid,
    input wire logic             out_valid,
    input wire logic             out_sat
);

    // sample command accepted, kind is the top bit of the word
    logic sample_in;

    assign sample_in = in_valid && (in_word[CMD_W-1] == KIND_SAMPLE);

    // one result three edges after each sample and none otherwise
    latency_check: assert property (
        @(posedge clk) disable iff (reset) out_valid == $past(sample_in, 3)
    ) else $error("out_valid does not follow a sample command by three cycles");

    // reset clears both output strobes
    reset_state_check: assert property (
        @(posedge clk) reset |=> (!out_valid && !out_sat)
    ) else $error("out_valid or out_sat high during reset");

    // saturation is only flagged on a valid output
    sat_valid_check: assert property (
        @(posedge clk) disable iff (reset) out_sat |-> out_valid
    ) else $error("out_sat high without out_valid");

endmodule

`default_nettype wire

//--- design/fxp_scaler_top.sv
/* fixed point scaler top
   decode, execute and cast stages, three cycles from command to result */

`timescale 1ns/1ps
`default_nettype none

module fxp_scaler_top
    import fxp_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [CMD_W-1:0]   in_word,
    input  wire logic               in_valid,
    output logic signed [OUT_W-1:0] out_word,
    output logic                    out_valid,
    output logic                    out_sat
);

    // decode to execute
    logic                       op_valid;
    logic [1:0]                 op;
    logic signed [SAMPLE_W-1:0] op_data;
    logic signed [COEF_W-1:0]   op_coef;

    // execute to result
    logic                       acc_valid;
    logic signed [ACC_W-1:0]    acc_value;

    // stage 1, command split and gain register
    cmd_decoder u_cmd_decoder (
        .clk      (clk),
        .reset    (reset),
        .in_word  (in_word),
        .in_valid (in_valid),
        .op_valid (op_valid),
        .op       (op),
        .op_data  (op_data),
        .op_coef  (op_coef)
    );

    // stage 2, multiply and accumulate
    fxp_mac u_fxp_mac (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op        (op),
        .op_data   (op_data),
        .op_coef   (op_coef),
        .acc_valid (acc_valid),
        .acc_value (acc_value)
    );

    // stage 3, cast back to Q8.8
    signed_cast u_signed_cast (
        .clk       (clk),
        .reset     (reset),
        .acc_valid (acc_valid),
        .acc_value (acc_value),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_sat   (out_sat)
    );

endmodule

`default_nettype wire

//--- design/signed_cast.sv
/* result stage
   casts Q12.22 down to Q8.8 by truncation and saturates the whole word */

`timescale 1ns/1ps
`default_nettype none

module signed_cast
    import fxp_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    acc_valid,
    input  wire logic signed [ACC_W-1:0] acc_value,
    output logic                         out_valid,
    output logic signed [OUT_W-1:0]      out_word,
    output logic                         out_sat
);

    // sign bit together with the integer bits that get dropped
    logic [CAST_GUARD_W-1:0] guard;

    // kept bits, top integer and top fractional bits
    logic signed [OUT_W-1:0] kept;

    logic pos_ovf;
    logic neg_ovf;
    logic sat;

    logic signed [OUT_W-1:0] cast_word;

    // lower fractional bits are just cut, which rounds toward -inf
    assign kept = acc_value[CAST_LSB +: OUT_W];

    // guard covers the input sign down to the output sign bit
    assign guard = acc_value[ACC_W-1 -: CAST_GUARD_W];

    // positive with a one above the output range
    assign pos_ovf = ~guard[CAST_GUARD_W-1] & (|guard);

    // negative with a zero above the output range
    assign neg_ovf = guard[CAST_GUARD_W-1] & ~(&guard);

    assign sat = pos_ovf | neg_ovf;

    // full word limits, so the negative limit is the true minimum
    always_comb begin
        if (pos_ovf) begin
            cast_word = OUT_MAX;
        end else if (neg_ovf) begin
            cast_word = OUT_MIN;
        end else begin
            cast_word = kept;
        end
    end

    // control: strobe and saturation flag
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_sat   <= 1'b0;
        end else begin
            out_valid <= acc_valid;
            // flag only ever set alongside a valid output
            out_sat   <= acc_valid & sat;
        end
    end

    // output word
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            out_word <= cast_word;
        end
    end

endmodule

`default_nettype wire

//--- design/fxp_mac.sv
/* execute stage
   signed multiply by the gain, accumulate or pass the sample through */

`timescale 1ns/1ps
`default_nettype none

module fxp_mac
    import fxp_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       op_valid,
    input  wire logic [1:0]                 op,
    input  wire logic signed [SAMPLE_W-1:0] op_data,
    input  wire logic signed [COEF_W-1:0]   op_coef,
    output logic                            acc_valid,
    output logic signed [ACC_W-1:0]         acc_value
);

    // Q10.22 product of sample and gain
    logic signed [PROD_W-1:0] prod;

    // product widened to Q12.22
    logic signed [ACC_W-1:0] prod_ext;

    // sample moved into Q12.22 for pass
    logic signed [ACC_W-1:0] pass_ext;

    // running accumulator and its next value
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_sum;
    logic signed [ACC_W-1:0] acc_next;

    // value sent to the result stage
    logic signed [ACC_W-1:0] result;

    // both operands signed, full width product
    assign prod = op_data * op_coef;

    // sign extension through the signed cast
    assign prod_ext = ACC_W'(prod);

    // Q8.8 to Q12.22 is a sign extend then a shift by the point difference
    assign pass_ext = ACC_W'(op_data) <<< (ACC_POINT - SAMPLE_POINT);

    // wraps modulo 2^ACC_W, no saturation in the accumulator
    assign acc_sum = acc + prod_ext;

    always_comb begin
        acc_next = acc;
        result   = pass_ext;
        case (op)
            OP_MUL: begin
                // restart the sum with this product
                acc_next = prod_ext;
                result   = prod_ext;
            end
            OP_MAC: begin
                acc_next = acc_sum;
                result   = acc_sum;
            end
            default: begin
                // pass and the reserved code leave the sum alone
                acc_next = acc;
                result   = pass_ext;
            end
        endcase
    end

    // control: strobe and accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
            acc       <= '0;
        end else begin
            acc_valid <= op_valid;
            // idle cycles hold the sum
            if (op_valid) begin
                acc <= acc_next;
            end
        end
    end

    // result register, follows the strobe
    always_ff @(posedge clk) begin
        if (op_valid) begin
            acc_value <= result;
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_decoder.sv
/* command decoder
   splits command words, keeps the gain and issues sample operations */

`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import fxp_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [CMD_W-1:0]           in_word,
    input  wire logic                       in_valid,
    output logic                            op_valid,
    output logic [1:0]                      op,
    output logic signed [SAMPLE_W-1:0]      op_data,
    output logic signed [COEF_W-1:0]        op_coef
);

    // incoming word seen through both views
    cmd_word_u cmd;

    // current gain, Q2.14
    logic signed [COEF_W-1:0] gain;

    logic is_sample;
    logic is_coef;

    assign cmd = cmd_word_u'(in_word);

    // kind is the same bit in either view
    assign is_sample = in_valid && (cmd.sample_view.kind == KIND_SAMPLE);
    assign is_coef   = in_valid && (cmd.coef_view.kind == KIND_COEF);

    // control: gain register and the op strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            gain     <= COEF_ONE;
            op_valid <= 1'b0;
        end else begin
            // coefficient loads never produce an op
            op_valid <= is_sample;
            if (is_coef) begin
                gain <= signed'(cmd.coef_view.coef);
            end
        end
    end

    // payload of a sample command
    // gain here is the registered value, so a load one cycle
    // earlier is already visible to this sample
    always_ff @(posedge clk) begin
        if (is_sample) begin
            op      <= cmd.sample_view.op;
            op_data <= signed'(cmd.sample_view.data);
            op_coef <= gain;
        end
    end

endmodule

`default_nettype wire

//--- design/fxp_pkg.sv
/* fixed point scaler package
   formats, opcodes and the command word layout shared by all stages */

`default_nettype none

package fxp_pkg;

    // command word
    localparam int CMD_W = 24;

    // sample in Q8.8
    localparam int SAMPLE_W     = 16;
    localparam int SAMPLE_POINT = 8;

    // gain in Q2.14
    localparam int COEF_W     = 16;
    localparam int COEF_POINT = 14;
    localparam logic signed [COEF_W-1:0] COEF_ONE = COEF_W'(1) << COEF_POINT;

    // product Q10.22, accumulator Q12.22
    localparam int PROD_W    = SAMPLE_W + COEF_W;
    localparam int ACC_W     = 34;
    localparam int ACC_POINT = SAMPLE_POINT + COEF_POINT;

    // output in Q8.8
    localparam int OUT_W     = 16;
    localparam int OUT_POINT = 8;

    // cast from accumulator to output format
    // fractional bits dropped below the kept word
    localparam int CAST_LSB = ACC_POINT - OUT_POINT;
    // sign bit plus the integer bits that do not survive the cast
    localparam int CAST_GUARD_W = (ACC_W - ACC_POINT) - (OUT_W - OUT_POINT) + 1;

    // saturation limits of the output word
    localparam logic signed [OUT_W-1:0] OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
    localparam logic signed [OUT_W-1:0] OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

    // operation codes, 2'b11 is reserved and acts as pass
    localparam logic [1:0] OP_MUL  = 2'b00;
    localparam logic [1:0] OP_MAC  = 2'b01;
    localparam logic [1:0] OP_PASS = 2'b10;

    // top bit of the command word
    localparam logic KIND_SAMPLE = 1'b0;
    localparam logic KIND_COEF   = 1'b1;

    // one 24 bit word, two decodings picked by kind
    typedef union packed {
        // sample command
        struct packed {
            logic                kind;
            logic [1:0]          op;
            logic [4:0]          rsvd;
            logic [SAMPLE_W-1:0] data;
        } sample_view;
        // coefficient load
        struct packed {
            logic              kind;
            logic [6:0]        rsvd;
            logic [COEF_W-1:0] coef;
        } coef_view;
    } cmd_word_u;

endpackage

`default_nettype wire
